/* flist.f */
+incdir+include
src/mem_test_pkg.sv
src/pattern_gen.sv
src/stripe_router.sv
src/sram_ctrl.sv
src/result_checker.sv
src/mem_test_top.sv
sim/sram_model.sv
sim/mem_test_asserts.sv
sim/mem_test_tb.sv

/* include/mem_test_cfg.svh */
`ifndef MEM_TEST_CFG_SVH
`define MEM_TEST_CFG_SVH

// ----------------------------------------------------------------------
// Geometry of the striped SRAM pair
// ----------------------------------------------------------------------
`define MT_ADDR_W 10                // Linear address bits.
`define MT_DATA_W 16                // SRAM data bus width.
`define MT_WORDS  (1 << `MT_ADDR_W) // Words covered by one run.

// ----------------------------------------------------------------------
// SRAM cycle timing and test pattern
// ----------------------------------------------------------------------
`define MT_ACCESS_CYCLES 2 // Strobe length in clocks.

// XORed into the low address bits, sized to MT_DATA_W.
`define MT_PATTERN_KEY 16'hA5C3

`endif

/* run.sh */
#!/bin/sh
# Build and run the striped SRAM self-test simulation with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module mem_test_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vmem_test_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* sim/mem_test_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_test_asserts (
  input wire       CLK,
  input wire       rst_n,
  input wire       sram_a_ce_n,
  input wire       sram_a_we_n,
  input wire       sram_a_oe_n,
  input wire       drive_a,
  input wire       sram_b_ce_n,
  input wire       sram_b_we_n,
  input wire       sram_b_oe_n,
  input wire       drive_b,
  input wire       test_done,
  input wire       test_pass,
  input wire [7:0] err_count
);

  // ----------------------------------------------------------------------
  // SRAM pin protocol, one set per chip
  // ----------------------------------------------------------------------
  strobe_excl_a: assert property (@(posedge CLK) disable iff (!rst_n)
    sram_a_we_n || sram_a_oe_n) else $error("Chip A we_n and oe_n low together.");
  strobe_excl_b: assert property (@(posedge CLK) disable iff (!rst_n)
    sram_b_we_n || sram_b_oe_n) else $error("Chip B we_n and oe_n low together.");

  bus_drive_a: assert property (@(posedge CLK) disable iff (!rst_n)
    drive_a |-> !sram_a_we_n) else $error("Chip A bus driven outside a write strobe.");
  bus_drive_b: assert property (@(posedge CLK) disable iff (!rst_n)
    drive_b |-> !sram_b_we_n) else $error("Chip B bus driven outside a write strobe.");

  // Chip enable must cover every strobe cycle.
  ce_cover_a: assert property (@(posedge CLK) disable iff (!rst_n)
    (!sram_a_we_n || !sram_a_oe_n) |-> !sram_a_ce_n) else $error("Chip A strobe without ce_n.");
  ce_cover_b: assert property (@(posedge CLK) disable iff (!rst_n)
    (!sram_b_we_n || !sram_b_oe_n) |-> !sram_b_ce_n) else $error("Chip B strobe without ce_n.");

  // ----------------------------------------------------------------------
  // Result outputs
  // ----------------------------------------------------------------------
  done_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
    test_done |=> !test_done) else $error("test_done held longer than one cycle.");
  errs_clear_pass: assert property (@(posedge CLK) disable iff (!rst_n)
    (err_count != 8'd0) |-> !test_pass) else $error("Errors counted while test_pass high.");

endmodule

`default_nettype wire

/* sim/mem_test_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_test_cfg.svh"

module mem_test_tb;

  localparam int HALF_WORDS  = `MT_WORDS / 2;
  localparam int RUN_TIMEOUT = 60000; // Cycles allowed for one run.

  logic                          CLK, rst_n, start;
  logic                          test_done, test_pass, led_done, led_fail;
  logic [7:0]                    err_count;
  logic [`MT_ADDR_W-2:0]         sram_a_addr, sram_b_addr;
  logic                          sram_a_ce_n, sram_a_we_n, sram_a_oe_n;
  logic                          sram_b_ce_n, sram_b_we_n, sram_b_oe_n;
  wire  [`MT_DATA_W-1:0]         sram_a_data, sram_b_data;
  logic                          fault_en_b;
  logic [$clog2(`MT_DATA_W)-1:0] fault_bit_b;
  logic [31:0]                   writes_a, writes_b;

  integer seed, rnd;
  int     check_errors, errors_at_start, tests_run, tests_failed;
  logic   timed_out, pass_at_start;
  string  cur_test;

  mem_test_top u_dut (
    .CLK(CLK), .rst_n(rst_n), .start(start), .test_done(test_done),
    .test_pass(test_pass), .err_count(err_count), .led_done(led_done), .led_fail(led_fail),
    .sram_a_addr(sram_a_addr), .sram_a_ce_n(sram_a_ce_n), .sram_a_we_n(sram_a_we_n),
    .sram_a_oe_n(sram_a_oe_n), .sram_a_data(sram_a_data),
    .sram_b_addr(sram_b_addr), .sram_b_ce_n(sram_b_ce_n), .sram_b_we_n(sram_b_we_n),
    .sram_b_oe_n(sram_b_oe_n), .sram_b_data(sram_b_data)
  );

  sram_model u_sram_a (
    .addr(sram_a_addr), .ce_n(sram_a_ce_n), .we_n(sram_a_we_n), .oe_n(sram_a_oe_n),
    .data(sram_a_data), .fault_en(1'b0), .fault_bit('0), .write_count(writes_a)
  );

  sram_model u_sram_b (
    .addr(sram_b_addr), .ce_n(sram_b_ce_n), .we_n(sram_b_we_n), .oe_n(sram_b_oe_n),
    .data(sram_b_data), .fault_en(fault_en_b), .fault_bit(fault_bit_b), .write_count(writes_b)
  );

  bind mem_test_top mem_test_asserts u_asserts (
    .CLK(CLK), .rst_n(rst_n),
    .sram_a_ce_n(sram_a_ce_n), .sram_a_we_n(sram_a_we_n), .sram_a_oe_n(sram_a_oe_n),
    .drive_a(u_ctrl_a.drive),
    .sram_b_ce_n(sram_b_ce_n), .sram_b_we_n(sram_b_we_n), .sram_b_oe_n(sram_b_oe_n),
    .drive_b(u_ctrl_b.drive),
    .test_done(test_done), .test_pass(test_pass), .err_count(err_count)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Address low bits XOR key.
  function automatic logic [`MT_DATA_W-1:0] expected_word(input int lin);
    logic [`MT_DATA_W-1:0] low_bits;
    low_bits = lin[`MT_DATA_W-1:0];
    return low_bits ^ `MT_PATTERN_KEY;
  endfunction

  // Odd addresses live in chip B, count those with bit_sel set, capped at 255.
  function automatic int faulty_reads(input int bit_sel);
    logic [`MT_DATA_W-1:0] word;
    int                    count;
    count = 0;
    for (int lin = 1; lin < `MT_WORDS; lin += 2) begin
      word = expected_word(lin);
      if (word[bit_sel]) count++;
    end
    return (count > 255) ? 255 : count;
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
      check_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = check_errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (timed_out || check_errors != errors_at_start) begin
      tests_failed++;
      $display("%s: failed", cur_test);
    end else begin
      $display("%s: passed", cur_test);
    end
  endtask

  // Pulses start, then waits for test_done plus one cycle for the LED.
  task automatic run_engine();
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    if (timed_out) return;
    @(negedge CLK);
    start = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    while (!seen && cycles < RUN_TIMEOUT) begin
      @(negedge CLK);
      cycles++;
      if (cycles == 2) pass_at_start = test_pass; // Just after run_start.
      seen = test_done;
    end
    if (!seen) begin
      $display("Timeout in %s: no test_done pulse within %0d cycles", cur_test, RUN_TIMEOUT);
      timed_out = 1'b1;
    end
    @(negedge CLK);
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    logic led_before;
    int   wa0, wb0, bad_a, bad_b, exp_errs, idx;
    seed = 32'h2ecd_f7a5;
    rst_n = 1'b0;
    start = 1'b0;
    fault_en_b = 1'b0;
    fault_bit_b = '0;
    check_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    timed_out = 1'b0;
    pass_at_start = 1'b0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;
    @(negedge CLK);

    begin_test("reset_state");
    check_value("strobes", 'h3f, {sram_a_ce_n, sram_a_we_n, sram_a_oe_n,
                                  sram_b_ce_n, sram_b_we_n, sram_b_oe_n});
    check_value("test_done", 0, test_done);
    check_value("test_pass", 1, test_pass);
    check_value("leds", 0, {led_done, led_fail});
    end_test();

    begin_test("clean_run");
    wa0 = writes_a;
    wb0 = writes_b;
    led_before = led_done;
    run_engine();
    check_value("test_pass", 1, test_pass);
    check_value("err_count", 0, err_count);
    check_value("led_done", !led_before, led_done);
    end_test();

    begin_test("striping");
    check_value("chip A writes", HALF_WORDS, writes_a - wa0);
    check_value("chip B writes", HALF_WORDS, writes_b - wb0);
    bad_a = 0;
    bad_b = 0;
    for (idx = 0; idx < HALF_WORDS; idx++) begin
      if (u_sram_a.mem[idx] !== expected_word(2 * idx)) bad_a++;
      if (u_sram_b.mem[idx] !== expected_word(2 * idx + 1)) bad_b++;
    end
    check_value("chip A bad words", 0, bad_a);
    check_value("chip B bad words", 0, bad_b);
    end_test();

    begin_test("fault_detect");
    rnd = $random(seed);
    fault_bit_b = rnd[$clog2(`MT_DATA_W)-1:0];
    while (faulty_reads(fault_bit_b) == 0) begin
      fault_bit_b = fault_bit_b + 1'b1; // Bit must show up in some odd pattern.
    end
    fault_en_b = 1'b1;
    exp_errs = faulty_reads(fault_bit_b);
    led_before = led_done;
    run_engine();
    check_value("test_pass", 0, test_pass);
    check_value("led_fail", 1, led_fail);
    check_value("err_count", exp_errs, err_count);
    check_value("led_done", !led_before, led_done);
    end_test();

    begin_test("repeat_run");
    fault_en_b = 1'b0;
    led_before = led_done;
    run_engine();
    check_value("test_pass at start", 1, pass_at_start);
    check_value("test_pass", 1, test_pass);
    check_value("err_count", 0, err_count);
    check_value("led_fail", 0, led_fail);
    check_value("led_done", !led_before, led_done);
    end_test();

    $display("Tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, check_errors);
    if (timed_out || tests_failed != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST OK");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/sram_model.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_test_cfg.svh"

module sram_model (
  input  wire  [`MT_ADDR_W-2:0]         addr,
  input  wire                           ce_n,
  input  wire                           we_n,
  input  wire                           oe_n,
  inout  wire  [`MT_DATA_W-1:0]         data,
  input  wire                           fault_en,
  input  wire  [$clog2(`MT_DATA_W)-1:0] fault_bit,
  output logic [31:0]                   write_count
);

  localparam int DEPTH = 1 << (`MT_ADDR_W - 1);

  logic [`MT_DATA_W-1:0] mem [DEPTH];
  logic [`MT_DATA_W-1:0] fault_mask;

  assign fault_mask = fault_en ? (`MT_DATA_W'(1) << fault_bit) : '0; // Stuck-at-zero bit.

  // Output drivers follow oe_n with no access delay.
  assign data = (!ce_n && !oe_n && we_n) ? (mem[addr] & ~fault_mask) : 'z;

  initial write_count = 0;

  // Data is taken a little after the write strobe opens.
  always @(negedge we_n) begin
    if (!ce_n) begin
      #2;
      mem[addr] = data;
      write_count = write_count + 1;
    end
  end

endmodule

`default_nettype wire

/* src/mem_test_pkg.sv */
`default_nettype none

`include "mem_test_cfg.svh"

package mem_test_pkg;

  typedef logic [`MT_DATA_W-1:0] data_word_t; // One SRAM word.

  // Low bit picks the chip, the rest is the address inside it.
  typedef struct packed {
    logic [`MT_ADDR_W-2:0] chip_addr; // Address within one chip.
    logic                  stripe_sel; // 0 selects chip A.
  } striped_addr_t;

  typedef union packed {
    logic [`MT_ADDR_W-1:0] linear;  // Plain word index.
    striped_addr_t         striped; // Chip select view.
  } lin_addr_t;

  // Expected content of a linear address.
  function automatic data_word_t pattern_word(lin_addr_t addr);
    return data_word_t'(addr.linear) ^ data_word_t'(`MT_PATTERN_KEY);
  endfunction

endpackage

`default_nettype wire

/* src/mem_test_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_test_cfg.svh"

module mem_test_top
  import mem_test_pkg::*;
(
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  start,
  output logic                  test_done,
  output logic                  test_pass,
  output logic [7:0]            err_count,
  output logic                  led_done,
  output logic                  led_fail,
  output logic [`MT_ADDR_W-2:0] sram_a_addr,
  output logic                  sram_a_ce_n,
  output logic                  sram_a_we_n,
  output logic                  sram_a_oe_n,
  inout  wire  [`MT_DATA_W-1:0] sram_a_data,
  output logic [`MT_ADDR_W-2:0] sram_b_addr,
  output logic                  sram_b_ce_n,
  output logic                  sram_b_we_n,
  output logic                  sram_b_oe_n,
  inout  wire  [`MT_DATA_W-1:0] sram_b_data
);

  // ----------------------------------------------------------------------
  // Stage interconnect
  // ----------------------------------------------------------------------
  logic                  op_req, op_ack, op_write;
  lin_addr_t             op_addr;
  data_word_t            op_wdata;
  logic                  run_start, reads_issued;
  logic                  ctl_a_req, ctl_a_ack, ctl_a_write;
  logic [`MT_ADDR_W-2:0] ctl_a_addr;
  data_word_t            ctl_a_wdata, ctl_a_rdata;
  logic                  ctl_b_req, ctl_b_ack, ctl_b_write;
  logic [`MT_ADDR_W-2:0] ctl_b_addr;
  data_word_t            ctl_b_wdata, ctl_b_rdata;
  logic                  rd_valid;
  lin_addr_t             rd_addr;
  data_word_t            rd_data;

  pattern_gen u_pattern_gen (
    .CLK(CLK), .rst_n(rst_n), .start(start), .op_ack(op_ack),
    .op_req(op_req), .op_write(op_write), .op_addr(op_addr), .op_wdata(op_wdata),
    .run_start(run_start), .reads_issued(reads_issued)
  );

  stripe_router u_router (
    .CLK(CLK), .rst_n(rst_n),
    .op_req(op_req), .op_write(op_write), .op_addr(op_addr), .op_wdata(op_wdata),
    .op_ack(op_ack),
    .ctl_a_req(ctl_a_req), .ctl_a_write(ctl_a_write), .ctl_a_addr(ctl_a_addr),
    .ctl_a_wdata(ctl_a_wdata), .ctl_a_ack(ctl_a_ack), .ctl_a_rdata(ctl_a_rdata),
    .ctl_b_req(ctl_b_req), .ctl_b_write(ctl_b_write), .ctl_b_addr(ctl_b_addr),
    .ctl_b_wdata(ctl_b_wdata), .ctl_b_ack(ctl_b_ack), .ctl_b_rdata(ctl_b_rdata),
    .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_data(rd_data)
  );

  sram_ctrl u_ctrl_a ( // Even linear addresses.
    .CLK(CLK), .rst_n(rst_n), .req(ctl_a_req), .write(ctl_a_write),
    .addr(ctl_a_addr), .wdata(ctl_a_wdata), .ack(ctl_a_ack), .rdata(ctl_a_rdata),
    .sram_addr(sram_a_addr), .sram_ce_n(sram_a_ce_n), .sram_we_n(sram_a_we_n),
    .sram_oe_n(sram_a_oe_n), .sram_data(sram_a_data)
  );

  sram_ctrl u_ctrl_b ( // Odd linear addresses.
    .CLK(CLK), .rst_n(rst_n), .req(ctl_b_req), .write(ctl_b_write),
    .addr(ctl_b_addr), .wdata(ctl_b_wdata), .ack(ctl_b_ack), .rdata(ctl_b_rdata),
    .sram_addr(sram_b_addr), .sram_ce_n(sram_b_ce_n), .sram_we_n(sram_b_we_n),
    .sram_oe_n(sram_b_oe_n), .sram_data(sram_b_data)
  );

  result_checker u_checker (
    .CLK(CLK), .rst_n(rst_n), .run_start(run_start), .reads_issued(reads_issued),
    .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_data(rd_data),
    .test_done(test_done), .test_pass(test_pass), .err_count(err_count),
    .led_done(led_done), .led_fail(led_fail)
  );

endmodule

`default_nettype wire

/* src/pattern_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_test_cfg.svh"

module pattern_gen
  import mem_test_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       start,
  input  logic       op_ack,
  output logic       op_req,
  output logic       op_write,
  output lin_addr_t  op_addr,
  output data_word_t op_wdata,
  output logic       run_start,
  output logic       reads_issued
);

  localparam logic [1:0] S_IDLE    = 2'd0; // Waiting for start.
  localparam logic [1:0] S_REQ     = 2'd1; // Request up, waiting for ack.
  localparam logic [1:0] S_RELEASE = 2'd2; // Request down, waiting for ack low.

  logic [1:0] state;
  logic       last_addr;

  assign last_addr = (op_addr.linear == '1);
  assign op_wdata  = pattern_word(op_addr); // Don't care on reads.

  // ----------------------------------------------------------------------
  // Write pass followed by read pass, one handshake per address
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state        <= S_IDLE;
      op_req       <= 1'b0;
      op_write     <= 1'b0;
      op_addr      <= '0;
      run_start    <= 1'b0;
      reads_issued <= 1'b0;
    end else begin
      run_start <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            run_start      <= 1'b1;
            reads_issued   <= 1'b0;
            op_addr.linear <= '0;
            op_write       <= 1'b1; // Writes go first.
            op_req         <= 1'b1;
            state          <= S_REQ;
          end
        end
        S_REQ: begin
          if (op_ack) begin
            op_req <= 1'b0;
            state  <= S_RELEASE;
            if (!op_write && last_addr) begin
              reads_issued <= 1'b1; // Final read accepted.
            end
          end
        end
        S_RELEASE: begin
          if (!op_ack) begin
            if (!last_addr) begin
              op_addr.linear <= op_addr.linear + 1'b1;
              op_req         <= 1'b1;
              state          <= S_REQ;
            end else if (op_write) begin
              op_addr.linear <= '0; // Wrap into the read pass.
              op_write       <= 1'b0;
              op_req         <= 1'b1;
              state          <= S_REQ;
            end else begin
              state <= S_IDLE;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/result_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_test_cfg.svh"

module result_checker
  import mem_test_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       run_start,
  input  logic       reads_issued,
  input  logic       rd_valid,
  input  lin_addr_t  rd_addr,
  input  data_word_t rd_data,
  output logic       test_done,
  output logic       test_pass,
  output logic [7:0] err_count,
  output logic       led_done,
  output logic       led_fail
);

  localparam int LEFT_W = `MT_ADDR_W + 1;

  data_word_t        expected;
  logic              mismatch;
  logic [LEFT_W-1:0] rd_left; // Reads not yet checked this run.
  logic              armed;
  logic              done_cnt; // Completed runs, modulo two.

  assign expected = pattern_word(rd_addr);
  assign mismatch = rd_valid && (rd_data != expected);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      test_done <= 1'b0;
      test_pass <= 1'b1;
      err_count <= '0;
      rd_left   <= '0;
      armed     <= 1'b0;
      done_cnt  <= 1'b0;
    end else begin
      test_done <= 1'b0;
      if (run_start) begin
        test_pass <= 1'b1;
        err_count <= '0;
        rd_left   <= LEFT_W'(`MT_WORDS);
        armed     <= 1'b1;
      end else begin
        if (rd_valid && rd_left != '0) begin
          rd_left <= rd_left - 1'b1;
        end
        if (mismatch) begin
          test_pass <= 1'b0;
          if (err_count != 8'hff) begin
            err_count <= err_count + 1'b1; // Saturates at 255.
          end
        end
        if (armed && reads_issued && rd_left == '0) begin
          test_done <= 1'b1;
          armed     <= 1'b0;
        end
      end
      if (test_done) begin
        done_cnt <= done_cnt + 1'b1;
      end
    end
  end

  assign led_done = done_cnt; // Toggles once per run.
  assign led_fail = !test_pass;

endmodule

`default_nettype wire

/* src/sram_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_test_cfg.svh"

module sram_ctrl
  import mem_test_pkg::*;
(
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  req,
  input  logic                  write,
  input  logic [`MT_ADDR_W-2:0] addr,
  input  data_word_t            wdata,
  output logic                  ack,
  output data_word_t            rdata,
  output logic [`MT_ADDR_W-2:0] sram_addr,
  output logic                  sram_ce_n,
  output logic                  sram_we_n,
  output logic                  sram_oe_n,
  inout  wire  [`MT_DATA_W-1:0] sram_data
);

  localparam int CNT_W = $clog2(`MT_ACCESS_CYCLES + 1);

  logic             busy;
  logic [CNT_W-1:0] cnt;
  logic             drive;
  logic             start_cycle;
  logic             last_strobe;

  assign start_cycle = req && !busy && !ack;
  assign last_strobe = busy && (cnt == CNT_W'(`MT_ACCESS_CYCLES));

  // Router holds wdata stable until ack, so it feeds the pins directly.
  assign sram_data = drive ? wdata : 'z;

  // ----------------------------------------------------------------------
  // Setup cycle, strobe cycles, then ack until req drops
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      cnt       <= '0;
      ack       <= 1'b0;
      drive     <= 1'b0;
      sram_ce_n <= 1'b1;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
    end else begin
      if (start_cycle) begin
        busy      <= 1'b1;
        cnt       <= '0;
        sram_ce_n <= 1'b0; // Address setup cycle.
      end else if (last_strobe) begin
        busy      <= 1'b0;
        ack       <= 1'b1;
        drive     <= 1'b0;
        sram_ce_n <= 1'b1;
        sram_we_n <= 1'b1;
        sram_oe_n <= 1'b1;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == '0) begin
          sram_we_n <= !write; // Strobe starts.
          sram_oe_n <= write;
          drive     <= write;
        end
      end else if (ack && !req) begin
        ack <= 1'b0;
      end
    end
  end

  // Address latch and read capture.
  always_ff @(posedge CLK) begin
    if (start_cycle) begin
      sram_addr <= addr;
    end
    if (last_strobe && !write) begin
      rdata <= sram_data; // Sampled at the end of the last strobe cycle.
    end
  end

endmodule

`default_nettype wire

/* src/stripe_router.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_test_cfg.svh"

module stripe_router
  import mem_test_pkg::*;
(
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  op_req,
  input  logic                  op_write,
  input  lin_addr_t             op_addr,
  input  data_word_t            op_wdata,
  output logic                  op_ack,
  output logic                  ctl_a_req,
  output logic                  ctl_a_write,
  output logic [`MT_ADDR_W-2:0] ctl_a_addr,
  output data_word_t            ctl_a_wdata,
  input  logic                  ctl_a_ack,
  input  data_word_t            ctl_a_rdata,
  output logic                  ctl_b_req,
  output logic                  ctl_b_write,
  output logic [`MT_ADDR_W-2:0] ctl_b_addr,
  output data_word_t            ctl_b_wdata,
  input  logic                  ctl_b_ack,
  input  data_word_t            ctl_b_rdata,
  output logic                  rd_valid,
  output lin_addr_t             rd_addr,
  output data_word_t            rd_data
);

  logic      launch_a;
  logic      launch_b;
  logic      done_a;
  logic      done_b;
  logic      a_read_done;
  lin_addr_t addr_a_lin;
  lin_addr_t addr_b_lin;

  // A link is free only once both req and ack are back low.
  assign launch_a = op_req && !op_ack && !op_addr.striped.stripe_sel &&
                    !ctl_a_req && !ctl_a_ack;
  assign launch_b = op_req && !op_ack && op_addr.striped.stripe_sel &&
                    !ctl_b_req && !ctl_b_ack;

  assign done_a      = ctl_a_req && ctl_a_ack;
  assign a_read_done = done_a && !ctl_a_write;
  assign done_b      = ctl_b_req && ctl_b_ack && !a_read_done; // A wins a tie.

  // Linear address of each in-flight op, rebuilt from the chip address.
  always_comb begin
    addr_a_lin.striped.chip_addr  = ctl_a_addr;
    addr_a_lin.striped.stripe_sel = 1'b0;
    addr_b_lin.striped.chip_addr  = ctl_b_addr;
    addr_b_lin.striped.stripe_sel = 1'b1;
  end

  // ----------------------------------------------------------------------
  // Handshake state
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      op_ack    <= 1'b0;
      ctl_a_req <= 1'b0;
      ctl_b_req <= 1'b0;
      rd_valid  <= 1'b0;
    end else begin
      if (launch_a || launch_b) begin
        op_ack <= 1'b1; // Accepted once handed on.
      end else if (!op_req) begin
        op_ack <= 1'b0;
      end

      if (launch_a) begin
        ctl_a_req <= 1'b1;
      end else if (done_a) begin
        ctl_a_req <= 1'b0;
      end

      if (launch_b) begin
        ctl_b_req <= 1'b1;
      end else if (done_b) begin
        ctl_b_req <= 1'b0;
      end

      rd_valid <= a_read_done || (done_b && !ctl_b_write);
    end
  end

  // Payload registers.
  always_ff @(posedge CLK) begin
    if (launch_a) begin
      ctl_a_write <= op_write;
      ctl_a_addr  <= op_addr.striped.chip_addr;
      ctl_a_wdata <= op_wdata;
    end
    if (launch_b) begin
      ctl_b_write <= op_write;
      ctl_b_addr  <= op_addr.striped.chip_addr;
      ctl_b_wdata <= op_wdata;
    end
    if (a_read_done) begin
      rd_addr <= addr_a_lin;
      rd_data <= ctl_a_rdata;
    end else if (done_b) begin
      rd_addr <= addr_b_lin;
      rd_data <= ctl_b_rdata;
    end
  end

endmodule

`default_nettype wire
